/* Makefile */
# Verilator flow for the memory stage

TOP = mem_stage_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

# build, run, then look for the pass line in the log
sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* build.f */
+incdir+src
src/mem_pkg.sv
src/mem_ctrl.sv
src/data_mem.sv
src/mem_reg.sv
src/mem_stage.sv
dv/mem_stage_chk.sv
dv/mem_stage_tb.sv

/* dv/mem_stage_chk.sv */
`timescale 1ns/1ns
`default_nettype none

// properties of the MEM/WB register, bound into mem_reg
module mem_stage_chk
    import mem_pkg::*;
(
    input wire logic    clk,
    input wire logic    rst_n,
    input wire logic    stall,
    input wire logic    flush,
    input wire logic    miss_align,
    input wire mem_wb_t mem_wb
);

    int unsigned n_fail = 0;  // failed assertions so far, read from the testbench

    // stall is the only back-pressure, bundle must not move
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> mem_wb == $past(mem_wb))
    else begin
        n_fail++;
        $error("mem_wb changed during a stalled cycle");
    end

    // flush leaves a bubble
    a_flush_clear: assert property (@(posedge clk) disable iff (!rst_n)
        flush && !stall |=> !mem_wb.en && !mem_wb.gpr_we)
    else begin
        n_fail++;
        $error("flushed cycle left en or gpr_we high");
    end

    // misaligned access never writes a gpr
    a_miss_no_we: assert property (@(posedge clk) disable iff (!rst_n)
        miss_align && !stall |=> !mem_wb.gpr_we)
    else begin
        n_fail++;
        $error("misaligned access left gpr_we high");
    end

endmodule

bind mem_reg mem_stage_chk i_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .stall      (stall),
    .flush      (flush),
    .miss_align (miss_align),
    .mem_wb     (mem_wb)
);

`default_nettype wire

/* dv/mem_stage_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_macros.svh"

// testbench for the memory access stage
module mem_stage_tb
    import mem_pkg::*;
();

    localparam int N_SL    = 16;  // stores followed by as many reloads and half as many others
    localparam int N_NOP   = 16;
    localparam int N_MIS   = 8;   // faulting accesses each reloaded later
    localparam int N_FLUSH = 4;   // 3 cycles each
    localparam int N_STALL = 48;
    localparam int RUN_CYCLES = 3 + 2 + 2 * N_SL + N_SL / 2 + N_NOP + 2 * N_MIS
                              + 3 * N_FLUSH + N_STALL + 3;
    localparam int MAX_CYCLES = RUN_CYCLES + 20;

    logic    clk;
    logic    rst_n;
    logic    stall;
    logic    flush;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;

    logic [31:0]        lfsr = 32'd9;                               // seed
    logic [`WORD_W-1:0] shadow  [`DMEM_DEPTH];                      // model memory
    logic               written [`DMEM_DEPTH] = '{default: 1'b0};  // word holds data
    mem_wb_t            exp_prev  = '0;    // last expected bundle
    logic               exp_known = 1'b1;  // expected out is defined
    string              test_name = "reset";
    string              stim_name = "reset";  // test of the entry on the inputs
    int                 n_checks  = 0;
    int                 n_errors  = 0;
    int                 cycles    = 0;

    mem_stage i_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .ex_mem (ex_mem),
        .stall  (stall),
        .flush  (flush),
        .mem_wb (mem_wb)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    // galois lfsr for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // n fresh bits with one step per bit
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // byte address whose random upper bits the memory drops
    function automatic logic [31:0] rand_addr(int idx_bits, logic odd);
        logic [31:0] hi;
        logic [31:0] idx;
        logic [31:0] low;
        hi  = rand_bits(24);
        idx = rand_bits(idx_bits);
        low = odd ? (32'd1 + (rand_bits(2) % 32'd3)) : 32'd0;  // 1..3 when odd
        return (hi << 8) | (idx << 2) | low;
    endfunction

    function automatic ex_mem_t entry(mem_op_e op, logic [31:0] addr, logic [31:0] data,
                                      logic en);
        ex_mem_t     e;
        logic [31:0] r;
        r          = rand_bits(6);
        e.en       = en;
        e.op       = op;
        e.alu_out  = addr;
        e.st_data  = data;
        e.dst_addr = r[4:0];  // random destination
        e.gpr_we   = r[5];
        return e;
    endfunction

    // expected bundle after one edge plus the model memory update
    function automatic mem_wb_t ref_step(ex_mem_t in, logic stl, logic fl, logic run);
        mem_wb_t                 e;
        logic                    ld;
        logic                    st;
        logic                    mis;
        logic [`DMEM_ADDR_W-1:0] idx;
        e   = '0;
        ld  = (in.op == MEM_OP_LDW);
        st  = (in.op == MEM_OP_STW);
        mis = (ld || st) && (in.alu_out[1:0] != 2'b00);  // nop never faults
        idx = in.alu_out[`DMEM_ADDR_W+1:2];              // wraps in 64 words
        if (!run) begin
            exp_known = 1'b1;
        end else if (stl) begin
            e = exp_prev;                                // hold and store nothing
        end else if (fl) begin
            exp_known = 1'b1;                            // bubble with the store dropped
        end else if (mis) begin
            e.en       = in.en;
            e.exp_code = EXP_MISS_ALIGN;
            exp_known  = 1'b1;
        end else begin
            e.en       = in.en;
            e.dst_addr = in.dst_addr;
            e.gpr_we   = in.gpr_we;
            exp_known  = 1'b1;
            if (ld) begin
                e.out     = shadow[idx];
                exp_known = written[idx];
            end else if (!st) begin
                e.out = in.alu_out;
            end
            if (st && in.en) begin
                shadow[idx]  = in.st_data;
                written[idx] = 1'b1;
            end
        end
        exp_prev = e;
        return e;
    endfunction

    task automatic check(string name, string field, logic [31:0] exp_val, logic [31:0] act_val);
        n_checks++;
        if (exp_val !== act_val) begin
            n_errors++;
            $display("ERR %s %s: expected %h, actual %h", name, field, exp_val, act_val);
        end
    endtask

    task automatic drive(ex_mem_t e, logic s, logic f);
        @(posedge clk);
        ex_mem    <= e;
        stall     <= s;
        flush     <= f;
        stim_name <= test_name;
    endtask

    // inputs taken at the rising edge and outputs compared at the falling edge
    initial begin : compare
        ex_mem_t cap_in;
        logic    cap_stall;
        logic    cap_flush;
        logic    cap_rst_n;
        string   cap_name;
        mem_wb_t exp_wb;
        forever begin
            @(posedge clk);
            cap_in    = ex_mem;
            cap_stall = stall;
            cap_flush = flush;
            cap_rst_n = rst_n;
            cap_name  = stim_name;
            exp_wb    = ref_step(cap_in, cap_stall, cap_flush, cap_rst_n);
            @(negedge clk);
            check(cap_name, "en", 32'(exp_wb.en), 32'(mem_wb.en));
            check(cap_name, "dst_addr", 32'(exp_wb.dst_addr), 32'(mem_wb.dst_addr));
            check(cap_name, "gpr_we", 32'(exp_wb.gpr_we), 32'(mem_wb.gpr_we));
            check(cap_name, "exp_code", 32'(exp_wb.exp_code), 32'(mem_wb.exp_code));
            if (exp_known) begin
                check(cap_name, "out", exp_wb.out, mem_wb.out);  // skipped for unwritten words
            end
        end
    end

    initial begin : watchdog
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : main
        logic [31:0] st_addr [$];  // aligned addresses already stored to
        logic [31:0] a;
        logic [31:0] r;
        mem_op_e     op;
        int          i;
        rst_n  = 1'b0;
        stall  = 1'b0;
        flush  = 1'b0;
        ex_mem = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) drive('0, 1'b0, 1'b0);  // just after reset

        test_name = "store_load";
        for (i = 0; i < N_SL; i++) begin
            a = rand_addr(6, 1'b0);
            st_addr.push_back(a);
            drive(entry(MEM_OP_STW, a, rand_bits(32), 1'b1), 1'b0, 1'b0);
        end
        for (i = 0; i < N_SL; i++) begin
            drive(entry(MEM_OP_LDW, st_addr[i], '0, 1'b1), 1'b0, 1'b0);
        end
        for (i = 0; i < N_SL / 2; i++) begin
            drive(entry(MEM_OP_LDW, rand_addr(6, 1'b0), '0, 1'b1), 1'b0, 1'b0);  // others
        end

        test_name = "nop_pass";
        for (i = 0; i < N_NOP; i++) begin
            if (i % 4 == 3) begin
                drive(entry(MEM_OP_STW, rand_addr(6, 1'b0), rand_bits(32), 1'b1), 1'b0, 1'b0);
            end else begin
                drive(entry(MEM_OP_NOP, rand_bits(32), rand_bits(32), 1'b1), 1'b0, 1'b0);
            end
        end

        test_name = "misalign";
        for (i = 0; i < N_MIS; i++) begin
            op = (i % 2 == 1) ? MEM_OP_STW : MEM_OP_LDW;
            a  = st_addr[i] | (32'd1 + (rand_bits(2) % 32'd3));
            drive(entry(op, a, rand_bits(32), 1'b1), 1'b0, 1'b0);
        end
        for (i = 0; i < N_MIS; i++) begin
            drive(entry(MEM_OP_LDW, st_addr[i], '0, 1'b1), 1'b0, 1'b0);  // unchanged words
        end

        test_name = "flush";
        for (i = 0; i < N_FLUSH; i++) begin
            a = rand_addr(6, 1'b0);
            drive(entry(MEM_OP_STW, a, rand_bits(32), 1'b1), 1'b0, 1'b0);
            drive(entry(MEM_OP_STW, a, rand_bits(32), 1'b1), 1'b0, 1'b1);  // dropped
            drive(entry(MEM_OP_LDW, a, '0, 1'b1), 1'b0, 1'b0);             // sees first store
        end

        test_name = "stall_invalid";
        for (i = 0; i < N_STALL; i++) begin
            r = rand_bits(8);
            case (r[1:0])
                2'd0:    op = MEM_OP_NOP;
                2'd2:    op = MEM_OP_STW;
                default: op = MEM_OP_LDW;
            endcase
            a = rand_addr(3, r[7] & r[2]);  // small window so loads hit stores
            drive(entry(op, a, rand_bits(32), r[4:3] != 2'd0), r[6:5] == 2'd0, 1'b0);
        end

        drive('0, 1'b0, 1'b0);
        repeat (2) @(posedge clk);
        $display("checks %0d, mismatches %0d, assertion failures %0d",
                 n_checks, n_errors, i_dut.i_reg.i_chk.n_fail);
        if (n_errors == 0 && i_dut.i_reg.i_chk.n_fail == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/data_mem.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_macros.svh"

// word-wide data memory
// async read, write on rising edge
module data_mem (
    input  wire logic                    clk,
    input  wire logic [`DMEM_ADDR_W-1:0] addr,     // word index
    input  wire logic                    wr,       // write strobe
    input  wire logic [`WORD_W-1:0]      wr_data,
    output logic [`WORD_W-1:0]           rd_data   // valid in same cycle
);

    // storage, contents unknown until first write
    logic [`WORD_W-1:0] mem [`DMEM_DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wr) begin
            mem[addr] <= wr_data;  // lands at the edge
        end
    end

    // read port, combinational
    // a store at edge N shows up here right after N
    assign rd_data = mem[addr];

endmodule

`default_nettype wire

/* src/mem_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_macros.svh"

// memory stage control, all combinational
module mem_ctrl
    import mem_pkg::*;
(
    input  wire ex_mem_t              ex_mem,
    input  wire logic                 stall,
    input  wire logic                 flush,
    input  wire logic [`WORD_W-1:0]   rd_data,    // from data_mem, same cycle
    output logic [`DMEM_ADDR_W-1:0]   addr,       // word index
    output logic                      wr,         // store strobe
    output logic [`WORD_W-1:0]        wr_data,
    output logic [`WORD_W-1:0]        out,        // stage result to mem_reg
    output logic                      miss_align
);

    logic is_ld;   // load word decoded
    logic is_st;   // store word decoded
    logic low_set; // either byte offset bit set

    // opcode decode
    always_comb begin
        is_ld = 1'b0;
        is_st = 1'b0;
        unique case (ex_mem.op)
            MEM_OP_LDW: is_ld = 1'b1;
            MEM_OP_STW: is_st = 1'b1;
            default: begin
                // nop and the unused code touch no memory
                is_ld = 1'b0;
                is_st = 1'b0;
            end
        endcase
    end

    // word accesses need bits [1:0] clear
    assign low_set    = |ex_mem.alu_out[1:0];
    assign miss_align = (is_ld || is_st) && low_set; // nop never faults

    // word index, upper address bits dropped so access wraps
    assign addr = ex_mem.alu_out[`DMEM_ADDR_W+1:2];

    // only a real, aligned store that is moving forward writes
    assign wr      = ex_mem.en && is_st && !miss_align && !stall && !flush;
    assign wr_data = ex_mem.st_data;

    // result select
    always_comb begin
        if (is_ld) begin
            out = rd_data;          // loaded word
        end else if (is_st) begin
            out = '0;               // stores produce nothing
        end else begin
            out = ex_mem.alu_out;   // pass through
        end
    end

endmodule

`default_nettype wire

/* src/mem_macros.svh */
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// datapath widths for the memory stage

// one machine word
`define WORD_W       32

// general purpose register index
`define REG_ADDR_W   5

// on-chip data memory, word addressed
`define DMEM_DEPTH   64
`define DMEM_ADDR_W  6   // log2 of DMEM_DEPTH

// byte address bits [1:0] select a byte inside a word
// word index comes from the bits right above them
// anything above the word index wraps around

`endif

/* src/mem_pkg.sv */
`default_nettype none

`include "mem_macros.svh"

package mem_pkg;

    // memory opcode carried down from decode
    typedef enum logic [1:0] {
        MEM_OP_NOP = 2'b00,  // alu result passes through
        MEM_OP_LDW = 2'b01,  // load word
        MEM_OP_STW = 2'b10   // store word
    } mem_op_e;

    // exception raised by this stage
    typedef enum logic {
        EXP_NONE       = 1'b0,
        EXP_MISS_ALIGN = 1'b1  // word access off a 4-byte boundary
    } exp_code_e;

    // EX/MEM bundle, driven by the execute stage
    typedef struct packed {
        logic                   en;        // slot holds a real instruction
        mem_op_e                op;
        logic [`WORD_W-1:0]     alu_out;   // also the byte address
        logic [`WORD_W-1:0]     st_data;
        logic [`REG_ADDR_W-1:0] dst_addr;
        logic                   gpr_we;    // high = write the gpr
    } ex_mem_t;

    // MEM/WB bundle, consumed by writeback
    typedef struct packed {
        logic                   en;
        logic [`REG_ADDR_W-1:0] dst_addr;
        logic                   gpr_we;    // active high
        exp_code_e              exp_code;
        logic [`WORD_W-1:0]     out;       // stage result
    } mem_wb_t;

endpackage

`default_nettype wire

/* src/mem_reg.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_macros.svh"

// MEM/WB pipeline register
module mem_reg
    import mem_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire ex_mem_t            ex_mem,      // bundle fields pass through here
    input  wire logic [`WORD_W-1:0] out,         // result from mem_ctrl
    input  wire logic               miss_align,
    input  wire logic               stall,
    input  wire logic               flush,
    output mem_wb_t                 mem_wb
);

    // empty slot, also used on flush
    localparam mem_wb_t WB_IDLE = '{
        en:       1'b0,
        dst_addr: '0,
        gpr_we:   1'b0,
        exp_code: EXP_NONE,
        out:      '0
    };

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb <= WB_IDLE;
        end else if (stall) begin
            mem_wb <= mem_wb;              // hold
        end else if (flush) begin
            mem_wb <= WB_IDLE;             // bubble
        end else if (miss_align) begin
            // keep the slot but make writeback harmless
            mem_wb.en       <= ex_mem.en;
            mem_wb.dst_addr <= '0;
            mem_wb.gpr_we   <= 1'b0;       // no gpr write
            mem_wb.exp_code <= EXP_MISS_ALIGN;
            mem_wb.out      <= '0;
        end else begin
            mem_wb.en       <= ex_mem.en;  // invalid entries still move along
            mem_wb.dst_addr <= ex_mem.dst_addr;
            mem_wb.gpr_we   <= ex_mem.gpr_we;
            mem_wb.exp_code <= EXP_NONE;
            mem_wb.out      <= out;
        end
    end

endmodule

`default_nettype wire

/* src/mem_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_macros.svh"

// memory access stage top
// ctrl -> data_mem -> ctrl -> mem_reg
module mem_stage
    import mem_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire ex_mem_t ex_mem,   // from EX/MEM
    input  wire logic    stall,    // hold level
    input  wire logic    flush,    // clear level
    output mem_wb_t      mem_wb    // to writeback
);

    logic [`DMEM_ADDR_W-1:0] addr;       // word index
    logic                    wr;         // gated store strobe
    logic [`WORD_W-1:0]      wr_data;
    logic [`WORD_W-1:0]      rd_data;    // comb read data
    logic [`WORD_W-1:0]      out;        // selected result
    logic                    miss_align;

    mem_ctrl i_ctrl (
        .ex_mem     (ex_mem),
        .stall      (stall),
        .flush      (flush),
        .rd_data    (rd_data),
        .addr       (addr),
        .wr         (wr),
        .wr_data    (wr_data),
        .out        (out),
        .miss_align (miss_align)
    );

    data_mem i_dmem (
        .clk     (clk),
        .addr    (addr),
        .wr      (wr),
        .wr_data (wr_data),
        .rd_data (rd_data)
    );

    mem_reg i_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_mem     (ex_mem),
        .out        (out),
        .miss_align (miss_align),
        .stall      (stall),
        .flush      (flush),
        .mem_wb     (mem_wb)
    );

endmodule

`default_nettype wire
